// ==== src/xbar_cfg_pkg.sv ====
// Fixed crossbar sizing and address map; interleaved decode assumes BANK_SEL_LSB is 0
package xbar_cfg_pkg;

  // Port and bank counts
  localparam int unsigned NUM_PORTS  = 2;
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_DEPTH = 16;  // Words per bank

  // Widths
  localparam int unsigned ADDR_W     = 16;  // Word address
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BANK_IDX_W = $clog2(NUM_BANKS);
  localparam int unsigned LOCAL_W    = $clog2(BANK_DEPTH);

  // Interleaved mode takes the bank number from the low address bits
  localparam int unsigned BANK_SEL_LSB = 0;

  // Anything at or above this word address is unmapped
  localparam int unsigned MAPPED_WORDS = NUM_BANKS * BANK_DEPTH;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BANK_IDX_W-1:0] bank_idx_t;
  typedef logic [LOCAL_W-1:0]    local_addr_t;

  // Linear mode regions, each BANK_DEPTH words long and aligned to its size
  localparam addr_t REGION_BASE [NUM_BANKS] = '{
    16'h0000,  // Bank 0
    16'h0010,  // Bank 1
    16'h0020,  // Bank 2
    16'h0030   // Bank 3
  };

endpackage

// ==== src/xbar_msg_pkg.sv ====
// Messages between crossbar stages; every message is a one-cycle strobe without back-pressure
package xbar_msg_pkg;

  // Response status as seen by an initiator
  typedef enum logic [1:0] {
    OKAY     = 2'd0,
    DECERR   = 2'd1,  // Address outside the mapped space
    CONFLICT = 2'd2   // Bank taken by a lower-numbered port
  } status_e;

  // Request from an initiator
  typedef struct packed {
    logic                valid;
    logic                write;
    xbar_cfg_pkg::addr_t addr;
    xbar_cfg_pkg::data_t wdata;
  } port_req_t;

  // Request after address decode
  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic                      decerr;
    xbar_cfg_pkg::bank_idx_t   bank;
    xbar_cfg_pkg::local_addr_t local_addr;
    xbar_cfg_pkg::data_t       wdata;
  } routed_req_t;

  // Outcome of the bank access, kept per port
  typedef struct packed {
    logic    valid;
    logic    write;   // Result stage needs it to zero write data
    status_e status;
  } exec_status_t;

  // Response to an initiator
  typedef struct packed {
    logic                valid;
    status_e             status;
    xbar_cfg_pkg::data_t rdata;
  } port_rsp_t;

endpackage

// ==== src/addr_decode.sv ====
// Decode stage, one cycle; mode_i must stay put while requests from the last two cycles are in flight
`timescale 1ns/1ps

module addr_decode (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   mode_i,   // 1 = interleaved
  input  xbar_msg_pkg::port_req_t   [xbar_cfg_pkg::NUM_PORTS-1:0] req_i,
  output xbar_msg_pkg::routed_req_t [xbar_cfg_pkg::NUM_PORTS-1:0] routed_o
);

  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;

  routed_req_t [NUM_PORTS-1:0] routed_d;
  routed_req_t [NUM_PORTS-1:0] routed_q;
  logic        [NUM_PORTS-1:0] region_hit;  // Linear table match per port
  logic                        any_req;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      routed_d[p].valid = req_i[p].valid;
      routed_d[p].write = req_i[p].write;
      routed_d[p].wdata = req_i[p].wdata;
      region_hit[p]     = 1'b0;

      if (mode_i) begin
        // Bank bits come straight from the address and are dropped from the local index
        routed_d[p].bank       = req_i[p].addr[BANK_SEL_LSB +: BANK_IDX_W];
        routed_d[p].local_addr = req_i[p].addr[BANK_SEL_LSB + BANK_IDX_W +: LOCAL_W];
        routed_d[p].decerr     = (req_i[p].addr >= addr_t'(MAPPED_WORDS));
      end else begin
        routed_d[p].bank       = '0;
        routed_d[p].local_addr = req_i[p].addr[LOCAL_W-1:0];
        for (int b = 0; b < NUM_BANKS; b++) begin
          // Compare only the bits above the in-bank offset
          if (req_i[p].addr[ADDR_W-1:LOCAL_W] == REGION_BASE[b][ADDR_W-1:LOCAL_W]) begin
            routed_d[p].bank = bank_idx_t'(b);
            region_hit[p]    = 1'b1;
          end
        end
        routed_d[p].decerr = !region_hit[p];  // No region claims it
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        routed_q[p].valid <= 1'b0;
      end
    end else begin
      routed_q <= routed_d;
    end
  end

  assign routed_o = routed_q;

  always_comb begin
    any_req = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      any_req = any_req | req_i[p].valid;
    end
  end

  // A mode flip under traffic would route in-flight requests by mixed rules
  mode_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(any_req) || $past(any_req, 2)) |-> $stable(mode_i))
    else $error("mode_i changed while requests were in flight");

endmodule

// ==== src/bank_execute.sv ====
// Execute stage, one cycle; lowest port wins a bank and a read sees data from before a same-cycle write
`timescale 1ns/1ps

module bank_execute (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  xbar_msg_pkg::routed_req_t  [xbar_cfg_pkg::NUM_PORTS-1:0] routed_i,
  output xbar_msg_pkg::exec_status_t [xbar_cfg_pkg::NUM_PORTS-1:0] exec_status_o,
  output xbar_cfg_pkg::data_t        [xbar_cfg_pkg::NUM_PORTS-1:0] exec_rdata_o
);

  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;

  data_t mem [NUM_BANKS][BANK_DEPTH];

  logic         [NUM_PORTS-1:0] conflict;
  logic         [NUM_PORTS-1:0] grant;
  exec_status_t [NUM_PORTS-1:0] status_d;
  exec_status_t [NUM_PORTS-1:0] status_q;
  data_t        [NUM_PORTS-1:0] rdata_q;

  // Fixed priority, any lower port on the same bank takes it
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      conflict[p] = 1'b0;
      for (int q = 0; q < p; q++) begin
        if (routed_i[q].valid && !routed_i[q].decerr && routed_i[q].bank == routed_i[p].bank) begin
          conflict[p] = 1'b1;
        end
      end
      grant[p] = routed_i[p].valid && !routed_i[p].decerr && !conflict[p];

      status_d[p].valid = routed_i[p].valid;
      status_d[p].write = routed_i[p].write;
      if (routed_i[p].decerr) begin
        status_d[p].status = DECERR;
      end else if (conflict[p]) begin
        status_d[p].status = CONFLICT;
      end else begin
        status_d[p].status = OKAY;
      end
    end
  end

  // Memories clear on reset so reads after reset return zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        for (int w = 0; w < BANK_DEPTH; w++) begin
          mem[b][w] <= '0;
        end
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        status_q[p].valid <= 1'b0;
      end
    end else begin
      status_q <= status_d;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (grant[p] && routed_i[p].write) begin
          mem[routed_i[p].bank][routed_i[p].local_addr] <= routed_i[p].wdata;
        end
      end
    end
  end

  // Raw bank word, result stage masks it
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      rdata_q[p] <= mem[routed_i[p].bank][routed_i[p].local_addr];
    end
  end

  assign exec_status_o = status_q;
  assign exec_rdata_o  = rdata_q;

  // A port 1 conflict means port 0 took the bank in that same cycle
  port1_conflict_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (exec_status_o[1].valid && exec_status_o[1].status == CONFLICT)
      |-> (exec_status_o[0].valid && exec_status_o[0].status == OKAY))
    else $error("Port 1 received CONFLICT while port 0 did not win the bank");

endmodule

// ==== src/resp_return.sv ====
// Result stage, one cycle; rdata is zero for writes and for every non-OKAY response
`timescale 1ns/1ps

module resp_return (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  xbar_msg_pkg::exec_status_t [xbar_cfg_pkg::NUM_PORTS-1:0] exec_status_i,
  input  xbar_cfg_pkg::data_t        [xbar_cfg_pkg::NUM_PORTS-1:0] exec_rdata_i,
  output xbar_msg_pkg::port_rsp_t    [xbar_cfg_pkg::NUM_PORTS-1:0] rsp_o
);

  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;

  port_rsp_t [NUM_PORTS-1:0] rsp_d;
  port_rsp_t [NUM_PORTS-1:0] rsp_q;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      rsp_d[p].valid  = exec_status_i[p].valid;
      rsp_d[p].status = exec_status_i[p].status;
      // Only a successful read carries bank data
      if (exec_status_i[p].status == OKAY && !exec_status_i[p].write) begin
        rsp_d[p].rdata = exec_rdata_i[p];
      end else begin
        rsp_d[p].rdata = '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        rsp_q[p].valid <= 1'b0;
      end
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_rsp_check
    // Decode errors reach the initiator one cycle later with clean data
    decerr_zero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (exec_status_i[p].valid && exec_status_i[p].status == DECERR)
        |=> (rsp_o[p].valid && rsp_o[p].rdata == '0))
      else $error("Port %0d returned DECERR with non-zero data", p);
  end

endmodule

// ==== src/bank_xbar_top.sv ====
// Two-port, four-bank crossbar; responses arrive 3 cycles after each request, no back-pressure
`timescale 1ns/1ps

module bank_xbar_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  logic                                                 mode_i,  // 1 = interleaved
  input  xbar_msg_pkg::port_req_t [xbar_cfg_pkg::NUM_PORTS-1:0] req_i,
  output xbar_msg_pkg::port_rsp_t [xbar_cfg_pkg::NUM_PORTS-1:0] rsp_o
);

  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;

  routed_req_t  [NUM_PORTS-1:0] routed;       // Decode to execute
  exec_status_t [NUM_PORTS-1:0] exec_status;  // Execute to result
  data_t        [NUM_PORTS-1:0] exec_rdata;

  addr_decode u_addr_decode (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .mode_i   (mode_i),
    .req_i    (req_i),
    .routed_o (routed)
  );

  bank_execute u_bank_execute (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .routed_i      (routed),
    .exec_status_o (exec_status),
    .exec_rdata_o  (exec_rdata)
  );

  resp_return u_resp_return (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .exec_status_i (exec_status),
    .exec_rdata_i  (exec_rdata),
    .rsp_o         (rsp_o)
  );

endmodule

// ==== dv/xbar_checker.sv ====
// Compares responses at the falling edge; exp_i must already be delayed to line up with rsp_i
`timescale 1ns/1ps

module xbar_checker (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  xbar_msg_pkg::port_rsp_t [xbar_cfg_pkg::NUM_PORTS-1:0] rsp_i,
  input  xbar_msg_pkg::port_rsp_t [xbar_cfg_pkg::NUM_PORTS-1:0] exp_i,
  output int                                                   mismatch_cnt_o,
  output int                                                   other_cnt_o,
  output int                                                   rsp_cnt_o
);

  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;

  int mismatch_cnt = 0;
  int other_cnt = 0;
  int rsp_cnt = 0;

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (exp_i[p].valid && !rsp_i[p].valid) begin
          $display("Port %0d: expected response missing at %0t", p, $time);
          other_cnt++;
        end else if (!exp_i[p].valid && rsp_i[p].valid) begin
          $display("Port %0d: response without a request at %0t", p, $time);
          other_cnt++;
        end else if (exp_i[p].valid) begin
          rsp_cnt++;
          if (rsp_i[p].status !== exp_i[p].status) begin
            $display("MISMATCH rsp_o[%0d].status got %h expected %h",
                     p, rsp_i[p].status, exp_i[p].status);
            mismatch_cnt++;
          end
          if (rsp_i[p].rdata !== exp_i[p].rdata) begin
            $display("MISMATCH rsp_o[%0d].rdata got %h expected %h",
                     p, rsp_i[p].rdata, exp_i[p].rdata);
            mismatch_cnt++;
          end
        end
      end
    end
  end

  assign mismatch_cnt_o = mismatch_cnt;
  assign other_cnt_o    = other_cnt;
  assign rsp_cnt_o      = rsp_cnt;

endmodule

// ==== dv/tb_bank_xbar.sv ====
// Needs dv/xbar_cases.txt reachable from the run directory; mode changes in it follow two idle lines
`timescale 1ns/1ps

module tb_bank_xbar;

  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int PIPE_DEPTH = 3;  // Request to response latency

  typedef struct packed {
    logic                      mode;
    port_req_t [NUM_PORTS-1:0] req;
    port_rsp_t [NUM_PORTS-1:0] exp_rsp;
  } case_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      mode;
  port_req_t [NUM_PORTS-1:0] req;
  port_rsp_t [NUM_PORTS-1:0] rsp;
  port_rsp_t [NUM_PORTS-1:0] exp_now;  // Lines up with req
  port_rsp_t [NUM_PORTS-1:0] exp_pipe [PIPE_DEPTH];

  case_t       cases_q [$];
  int          gap_q [$];  // Idle cycles after each case
  int unsigned rand_state = 94;
  int          load_errs = 0;
  int          exp_total = 0;
  int          limit_cycles = 0;
  int          mismatch_cnt;
  int          other_cnt;
  int          rsp_cnt;

  always #(CLK_PERIOD / 2) clk = ~clk;

  bank_xbar_top DUT (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .mode_i  (mode),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  xbar_checker u_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .rsp_i          (rsp),
    .exp_i          (exp_pipe[PIPE_DEPTH-1]),
    .mismatch_cnt_o (mismatch_cnt),
    .other_cnt_o    (other_cnt),
    .rsp_cnt_o      (rsp_cnt)
  );

  function automatic int unsigned lcg_next(int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    int          gap;
    string       line;
    logic [31:0] f [15];
    case_t       c;
    fd = $fopen("dv/xbar_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/xbar_cases.txt");
      load_errs++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          if (line[0] == "-") begin  // Group end, random idle gap
            rand_state = lcg_next(rand_state);
            gap = int'((rand_state >> 16) % 4);
            if (gap_q.size() > 0) begin
              gap_q[gap_q.size()-1] += gap;
            end
          end else begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 15) begin
              $display("Malformed line in cases file: %s", line);
              load_errs++;
            end else begin
              c.mode       = f[0][0];
              c.req[0]     = '{f[1][0], f[2][0], f[3][ADDR_W-1:0], f[4]};
              c.req[1]     = '{f[5][0], f[6][0], f[7][ADDR_W-1:0], f[8]};
              c.exp_rsp[0] = '{f[9][0], status_e'(f[10][1:0]), f[11]};
              c.exp_rsp[1] = '{f[12][0], status_e'(f[13][1:0]), f[14]};
              cases_q.push_back(c);
              gap_q.push_back(0);
              exp_total += int'(f[9][0]) + int'(f[12][0]);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Expected responses follow the DUT pipeline
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < PIPE_DEPTH; s++) begin
        exp_pipe[s] <= '0;
      end
    end else begin
      exp_pipe[0] <= exp_now;
      for (int s = 1; s < PIPE_DEPTH; s++) begin
        exp_pipe[s] <= exp_pipe[s-1];
      end
    end
  end

  initial begin
    int total_gap;
    rst_n   = 1'b0;
    mode    = 1'b0;
    req     = '0;
    exp_now = '0;
    load_cases();
    total_gap = 0;
    foreach (gap_q[i]) begin
      total_gap += gap_q[i];
    end
    limit_cycles = cases_q.size() + total_gap + 10;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    foreach (cases_q[i]) begin
      @(posedge clk);
      mode    <= cases_q[i].mode;
      req     <= cases_q[i].req;
      exp_now <= cases_q[i].exp_rsp;
      repeat (gap_q[i]) begin
        @(posedge clk);
        req     <= '0;
        exp_now <= '0;
      end
    end
    @(posedge clk);
    req     <= '0;
    exp_now <= '0;
    repeat (PIPE_DEPTH + 1) @(posedge clk);  // Drain

    if (rsp_cnt != exp_total) begin
      $display("Number of checked responses differs from the cases file");
    end
    $display("Responses %0d of %0d, mismatches %0d, other errors %0d",
             rsp_cnt, exp_total, mismatch_cnt, other_cnt + load_errs);
    if (mismatch_cnt == 0 && other_cnt == 0 && load_errs == 0 &&
        rsp_cnt == exp_total && exp_total > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout after %0d clock cycles, the run did not finish", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== dv/xbar_cases.txt ====
# mode, port0 valid write addr wdata, port1 valid write addr wdata, all hex
# then expected port0 valid status rdata, port1 valid status rdata; status 0 OKAY 1 DECERR 2 CONFLICT
0 1 1 0003 a0000003 1 1 0015 b1000015 1 0 00000000 1 0 00000000
0 1 1 0028 c2000028 1 1 003f d300003f 1 0 00000000 1 0 00000000
0 1 0 0003 00000000 1 0 0015 00000000 1 0 a0000003 1 0 b1000015
0 1 0 0028 00000000 1 0 003f 00000000 1 0 c2000028 1 0 d300003f
-
0 1 1 0007 11110007 0 0 0000 00000000 1 0 00000000 0 0 00000000
0 1 0 0007 00000000 0 0 0000 00000000 1 0 11110007 0 0 00000000
0 1 0 0007 00000000 1 1 0002 deadbeef 1 0 11110007 1 2 00000000
0 1 0 0002 00000000 0 0 0000 00000000 1 0 00000000 0 0 00000000
0 1 1 0011 44440011 1 0 0015 00000000 1 0 00000000 1 2 00000000
0 0 0 0000 00000000 1 0 0011 00000000 0 0 00000000 1 0 44440011
-
0 1 0 0040 00000000 1 0 0003 00000000 1 1 00000000 1 0 a0000003
0 1 1 ffff 12345678 1 1 0100 87654321 1 1 00000000 1 1 00000000
0 0 0 0000 00000000 0 0 0000 00000000 0 0 00000000 0 0 00000000
0 0 0 0000 00000000 0 0 0000 00000000 0 0 00000000 0 0 00000000
-
1 1 0 000c 00000000 1 0 0015 00000000 1 0 a0000003 1 0 b1000015
1 1 0 0022 00000000 1 0 003f 00000000 1 0 c2000028 1 0 d300003f
1 1 0 001c 00000000 1 0 001d 00000000 1 0 11110007 1 0 00000000
1 1 0 0005 00000000 1 0 0009 00000000 1 0 44440011 1 2 00000000
1 1 1 0040 00000055 1 0 8000 00000000 1 1 00000000 1 1 00000000
1 1 1 000e 6666000e 0 0 0000 00000000 1 0 00000000 0 0 00000000
1 0 0 0000 00000000 1 0 000e 00000000 0 0 00000000 1 0 6666000e

// ==== filelist.f ====
src/xbar_cfg_pkg.sv
src/xbar_msg_pkg.sv
src/addr_decode.sv
src/bank_execute.sv
src/resp_return.sv
src/bank_xbar_top.sv
dv/xbar_checker.sv
dv/tb_bank_xbar.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
TOP       ?= tb_bank_xbar
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
